// ==== core_pkg.sv ====
package core_pkg;

    // datapath word width
    localparam int xlen = 32;

    // register index width and register count
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

endpackage

// ==== isa_pkg.sv ====
package isa_pkg;

    // field widths not covered by the register index width
    localparam int opcode_w = 6;
    localparam int funct_w  = 6;
    localparam int imm_w    = 16;

    // lsb position of each instruction field
    localparam int opcode_lsb = 26;
    localparam int rs_lsb     = 21;
    localparam int rt_lsb     = 16;
    localparam int rd_lsb     = 11;
    localparam int shamt_lsb  = 6;
    localparam int funct_lsb  = 0;
    localparam int imm_lsb    = 0;

    typedef enum logic [opcode_w-1:0] {
        opc_special = 6'h00,
        opc_addiu   = 6'h09,
        opc_slti    = 6'h0a,
        opc_andi    = 6'h0c,
        opc_ori     = 6'h0d,
        opc_xori    = 6'h0e,
        opc_lui     = 6'h0f
    } opcode_e;

    typedef enum logic [funct_w-1:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_sra  = 6'h03,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_nor  = 6'h27,
        fn_slt  = 6'h2a,
        fn_sltu = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        op_none,
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_nor,
        op_slt,
        op_sltu,
        op_sll,
        op_srl,
        op_sra,
        op_lui
    } alu_op_e;

endpackage

// ==== inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
    input  core_pkg::word_t     inst_i,
    output core_pkg::reg_addr_t rs_o,
    output core_pkg::reg_addr_t rt_o,
    output core_pkg::reg_addr_t waddr_o,
    output logic                reads_rs_o,
    output logic                reads_rt_o,
    output logic                reg_wen_o,
    output logic                sel_shamt_o,
    output logic                sel_imm_o,
    output core_pkg::word_t     imm_o,
    output isa_pkg::alu_op_e    alu_op_o
);
    import core_pkg::*;
    import isa_pkg::*;

    opcode_e          opcode;
    funct_e           funct;
    reg_addr_t        rd;
    logic [imm_w-1:0] imm16;
    logic             wen;

    assign opcode = opcode_e'(inst_i[opcode_lsb +: opcode_w]);
    assign funct  = funct_e'(inst_i[funct_lsb +: funct_w]);
    assign rs_o   = inst_i[rs_lsb +: reg_addr_w];
    assign rt_o   = inst_i[rt_lsb +: reg_addr_w];
    assign rd     = inst_i[rd_lsb +: reg_addr_w];
    assign imm16  = inst_i[imm_lsb +: imm_w];

    always_comb begin
        alu_op_o    = op_none;
        wen         = 1'b0;
        reads_rs_o  = 1'b0;
        reads_rt_o  = 1'b0;
        sel_shamt_o = 1'b0;
        sel_imm_o   = 1'b0;
        waddr_o     = rt_o;
        imm_o       = '0;
        case (opcode)
            opc_special: begin
                // r-type writes rd from rs and rt
                waddr_o    = rd;
                wen        = 1'b1;
                reads_rs_o = 1'b1;
                reads_rt_o = 1'b1;
                case (funct)
                    fn_sll:  alu_op_o = op_sll;
                    fn_srl:  alu_op_o = op_srl;
                    fn_sra:  alu_op_o = op_sra;
                    fn_addu: alu_op_o = op_add;
                    fn_subu: alu_op_o = op_sub;
                    fn_and:  alu_op_o = op_and;
                    fn_or:   alu_op_o = op_or;
                    fn_xor:  alu_op_o = op_xor;
                    fn_nor:  alu_op_o = op_nor;
                    fn_slt:  alu_op_o = op_slt;
                    fn_sltu: alu_op_o = op_sltu;
                    default: begin
                        wen        = 1'b0;
                        reads_rs_o = 1'b0;
                        reads_rt_o = 1'b0;
                    end
                endcase
                // shifts take shamt in place of rs
                if (alu_op_o inside {op_sll, op_srl, op_sra}) begin
                    reads_rs_o  = 1'b0;
                    sel_shamt_o = 1'b1;
                end
            end
            opc_addiu, opc_slti: begin
                wen        = 1'b1;
                reads_rs_o = 1'b1;
                sel_imm_o  = 1'b1;
                imm_o      = {{(xlen-imm_w){imm16[imm_w-1]}}, imm16};
                alu_op_o   = (opcode == opc_addiu) ? op_add : op_slt;
            end
            opc_andi, opc_ori, opc_xori: begin
                wen        = 1'b1;
                reads_rs_o = 1'b1;
                sel_imm_o  = 1'b1;
                imm_o      = {{(xlen-imm_w){1'b0}}, imm16};
                case (opcode)
                    opc_andi: alu_op_o = op_and;
                    opc_ori:  alu_op_o = op_or;
                    default:  alu_op_o = op_xor;
                endcase
            end
            opc_lui: begin
                wen       = 1'b1;
                sel_imm_o = 1'b1;
                imm_o     = {imm16, {(xlen-imm_w){1'b0}}};
                alu_op_o  = op_lui;
            end
            default: begin
                wen = 1'b0;
            end
        endcase
    end

    // r0 is never a real destination
    assign reg_wen_o = wen && (waddr_o != '0);

endmodule

// ==== issue_ctrl.sv ====
`timescale 1ns/1ps

module issue_ctrl (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                bundle_req_i,
    input  core_pkg::reg_addr_t m_waddr_i,
    input  core_pkg::reg_addr_t s_rs_i,
    input  core_pkg::reg_addr_t s_rt_i,
    input  logic                m_wen_i,
    input  logic                s_reads_rs_i,
    input  logic                s_reads_rt_i,
    output logic                master_go_o,
    output logic                slave_go_o,
    output logic                bundle_ack_o
);

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        SECOND,
        DONE
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   split;

    // slave reads what the master is about to write
    assign split = m_wen_i && ((s_reads_rs_i && (s_rs_i == m_waddr_i)) ||
                               (s_reads_rt_i && (s_rt_i == m_waddr_i)));

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (bundle_req_i) begin
                    state_d = ISSUE;
                end
            end
            ISSUE:   state_d = split ? SECOND : DONE;
            SECOND:  state_d = DONE;
            DONE: begin
                if (!bundle_req_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign master_go_o  = (state_q == ISSUE);
    assign slave_go_o   = ((state_q == ISSUE) && !split) || (state_q == SECOND);
    assign bundle_ack_o = (state_q == DONE);

    ack_needs_req: assert property (@(posedge clk) disable iff (reset_i)
        $rose(bundle_ack_o) |-> bundle_req_i);

    // a late slave must have been held back for a dependency that still holds
    second_after_skip: assert property (@(posedge clk) disable iff (reset_i)
        (state_q == SECOND) && slave_go_o |->
            split && $past((state_q == ISSUE) && !slave_go_o));

endmodule

// ==== lane_alu.sv ====
`timescale 1ns/1ps

module lane_alu (
    input  core_pkg::word_t     rs_val_i,
    input  core_pkg::word_t     rt_val_i,
    input  core_pkg::word_t     imm_i,
    input  core_pkg::reg_addr_t shamt_i,
    input  logic                sel_shamt_i,
    input  logic                sel_imm_i,
    input  isa_pkg::alu_op_e    alu_op_i,
    output core_pkg::word_t     result_o
);
    import core_pkg::*;
    import isa_pkg::*;

    word_t     op_a;
    word_t     op_b;
    reg_addr_t sh;

    assign op_a = sel_shamt_i ? {{(xlen-reg_addr_w){1'b0}}, shamt_i} : rs_val_i;
    assign op_b = sel_imm_i ? imm_i : rt_val_i;
    assign sh   = op_a[reg_addr_w-1:0];

    always_comb begin
        case (alu_op_i)
            // wraps like addu without an overflow trap
            op_add:  result_o = op_a + op_b;
            op_sub:  result_o = op_a - op_b;
            op_and:  result_o = op_a & op_b;
            op_or:   result_o = op_a | op_b;
            op_xor:  result_o = op_a ^ op_b;
            op_nor:  result_o = ~(op_a | op_b);
            op_slt:  result_o = ($signed(op_a) < $signed(op_b)) ? word_t'(1) : '0;
            op_sltu: result_o = (op_a < op_b) ? word_t'(1) : '0;
            op_sll:  result_o = op_b << sh;
            op_srl:  result_o = op_b >> sh;
            op_sra:  result_o = word_t'($signed(op_b) >>> sh);
            // immediate already shifted up by the decoder
            op_lui:  result_o = op_b;
            default: result_o = '0;
        endcase
    end

endmodule

// ==== regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic                clk,
    input  logic                reset_i,
    input  core_pkg::reg_addr_t m_rs_i,
    input  core_pkg::reg_addr_t m_rt_i,
    input  core_pkg::reg_addr_t s_rs_i,
    input  core_pkg::reg_addr_t s_rt_i,
    output core_pkg::word_t     m_rs_o,
    output core_pkg::word_t     m_rt_o,
    output core_pkg::word_t     s_rs_o,
    output core_pkg::word_t     s_rt_o,
    input  logic                m_we_i,
    input  logic                s_we_i,
    input  core_pkg::reg_addr_t m_waddr_i,
    input  core_pkg::reg_addr_t s_waddr_i,
    input  core_pkg::word_t     m_wdata_i,
    input  core_pkg::word_t     s_wdata_i,
    output logic                wb_m_en_o,
    output core_pkg::reg_addr_t wb_m_addr_o,
    output core_pkg::word_t     wb_m_data_o,
    output logic                wb_s_en_o,
    output core_pkg::reg_addr_t wb_s_addr_o,
    output core_pkg::word_t     wb_s_data_o
);
    import core_pkg::*;

    word_t regs [num_regs];

    function automatic word_t read_reg(input reg_addr_t addr);
        return (addr == '0) ? '0 : regs[addr];
    endfunction

    assign m_rs_o = read_reg(m_rs_i);
    assign m_rt_o = read_reg(m_rt_i);
    assign s_rs_o = read_reg(s_rs_i);
    assign s_rt_o = read_reg(s_rt_i);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (m_we_i) begin
                regs[m_waddr_i] <= m_wdata_i;
            end
            // slave is later in program order, so it lands last
            if (s_we_i) begin
                regs[s_waddr_i] <= s_wdata_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_m_en_o <= 1'b0;
            wb_s_en_o <= 1'b0;
        end else begin
            wb_m_en_o <= m_we_i;
            wb_s_en_o <= s_we_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_m_addr_o <= m_waddr_i;
        wb_m_data_o <= m_wdata_i;
        wb_s_addr_o <= s_waddr_i;
        wb_s_data_o <= s_wdata_i;
    end

    // decoders must already have dropped r0 writes
    no_r0_write: assert property (@(posedge clk) disable iff (reset_i)
        !(m_we_i && (m_waddr_i == '0)) && !(s_we_i && (s_waddr_i == '0)));

endmodule

// ==== dual_issue_core.sv ====
`timescale 1ns/1ps

module dual_issue_core (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                bundle_req_i,
    input  core_pkg::word_t     master_inst_i,
    input  core_pkg::word_t     slave_inst_i,
    output logic                bundle_ack_o,
    output logic                wb_m_en_o,
    output core_pkg::reg_addr_t wb_m_addr_o,
    output core_pkg::word_t     wb_m_data_o,
    output logic                wb_s_en_o,
    output core_pkg::reg_addr_t wb_s_addr_o,
    output core_pkg::word_t     wb_s_data_o
);
    import core_pkg::*;
    import isa_pkg::*;

    reg_addr_t m_rs, m_rt, m_waddr;
    reg_addr_t s_rs, s_rt, s_waddr;
    logic      s_reads_rs, s_reads_rt;
    logic      m_reg_wen, s_reg_wen;
    logic      m_sel_shamt, m_sel_imm;
    logic      s_sel_shamt, s_sel_imm;
    word_t     m_imm, s_imm;
    alu_op_e   m_alu_op, s_alu_op;
    word_t     m_rs_val, m_rt_val;
    word_t     s_rs_val, s_rt_val;
    word_t     m_result, s_result;
    logic      master_go, slave_go;

    inst_decoder dec_m_i (
        .inst_i      (master_inst_i),
        .rs_o        (m_rs),
        .rt_o        (m_rt),
        .waddr_o     (m_waddr),
        .reads_rs_o  (),
        .reads_rt_o  (),
        .reg_wen_o   (m_reg_wen),
        .sel_shamt_o (m_sel_shamt),
        .sel_imm_o   (m_sel_imm),
        .imm_o       (m_imm),
        .alu_op_o    (m_alu_op)
    );

    inst_decoder dec_s_i (
        .inst_i      (slave_inst_i),
        .rs_o        (s_rs),
        .rt_o        (s_rt),
        .waddr_o     (s_waddr),
        .reads_rs_o  (s_reads_rs),
        .reads_rt_o  (s_reads_rt),
        .reg_wen_o   (s_reg_wen),
        .sel_shamt_o (s_sel_shamt),
        .sel_imm_o   (s_sel_imm),
        .imm_o       (s_imm),
        .alu_op_o    (s_alu_op)
    );

    issue_ctrl issue_ctrl_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .bundle_req_i (bundle_req_i),
        .m_waddr_i    (m_waddr),
        .s_rs_i       (s_rs),
        .s_rt_i       (s_rt),
        .m_wen_i      (m_reg_wen),
        .s_reads_rs_i (s_reads_rs),
        .s_reads_rt_i (s_reads_rt),
        .master_go_o  (master_go),
        .slave_go_o   (slave_go),
        .bundle_ack_o (bundle_ack_o)
    );

    lane_alu alu_m_i (
        .rs_val_i    (m_rs_val),
        .rt_val_i    (m_rt_val),
        .imm_i       (m_imm),
        .shamt_i     (master_inst_i[shamt_lsb +: reg_addr_w]),
        .sel_shamt_i (m_sel_shamt),
        .sel_imm_i   (m_sel_imm),
        .alu_op_i    (m_alu_op),
        .result_o    (m_result)
    );

    lane_alu alu_s_i (
        .rs_val_i    (s_rs_val),
        .rt_val_i    (s_rt_val),
        .imm_i       (s_imm),
        .shamt_i     (slave_inst_i[shamt_lsb +: reg_addr_w]),
        .sel_shamt_i (s_sel_shamt),
        .sel_imm_i   (s_sel_imm),
        .alu_op_i    (s_alu_op),
        .result_o    (s_result)
    );

    regfile regfile_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .m_rs_i      (m_rs),
        .m_rt_i      (m_rt),
        .s_rs_i      (s_rs),
        .s_rt_i      (s_rt),
        .m_rs_o      (m_rs_val),
        .m_rt_o      (m_rt_val),
        .s_rs_o      (s_rs_val),
        .s_rt_o      (s_rt_val),
        .m_we_i      (m_reg_wen & master_go),
        .s_we_i      (s_reg_wen & slave_go),
        .m_waddr_i   (m_waddr),
        .s_waddr_i   (s_waddr),
        .m_wdata_i   (m_result),
        .s_wdata_i   (s_result),
        .wb_m_en_o   (wb_m_en_o),
        .wb_m_addr_o (wb_m_addr_o),
        .wb_m_data_o (wb_m_data_o),
        .wb_s_en_o   (wb_s_en_o),
        .wb_s_addr_o (wb_s_addr_o),
        .wb_s_data_o (wb_s_data_o)
    );

endmodule

// ==== tb_dual_issue_core.sv ====
`timescale 1ns/1ps

module tb_dual_issue_core;
    import core_pkg::*;
    import isa_pkg::*;

    typedef struct packed {
        int        at_edge;
        reg_addr_t addr;
        word_t     data;
    } wb_exp_t;

    logic      clk = 1'b0;
    logic      reset_i;
    logic      bundle_req_i;
    word_t     master_inst_i;
    word_t     slave_inst_i;
    logic      bundle_ack_o;
    logic      wb_m_en_o;
    reg_addr_t wb_m_addr_o;
    word_t     wb_m_data_o;
    logic      wb_s_en_o;
    reg_addr_t wb_s_addr_o;
    word_t     wb_s_data_o;

    int          cycle = 0;
    string       test_name = "reset";
    logic [31:0] rng = 32'h45e382d1;
    word_t       model_regs [num_regs];
    wb_exp_t     exp_m [$];
    wb_exp_t     exp_s [$];
    logic        due_m;
    logic        due_s;

    logic [5:0] r_functs [11] = '{fn_sll, fn_srl, fn_sra, fn_addu, fn_subu, fn_and,
                                  fn_or, fn_xor, fn_nor, fn_slt, fn_sltu};
    logic [5:0] i_opcodes [6] = '{opc_addiu, opc_slti, opc_andi, opc_ori, opc_xori, opc_lui};

    dual_issue_core dut_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .bundle_req_i  (bundle_req_i),
        .master_inst_i (master_inst_i),
        .slave_inst_i  (slave_inst_i),
        .bundle_ack_o  (bundle_ack_o),
        .wb_m_en_o     (wb_m_en_o),
        .wb_m_addr_o   (wb_m_addr_o),
        .wb_m_data_o   (wb_m_data_o),
        .wb_s_en_o     (wb_s_en_o),
        .wb_s_addr_o   (wb_s_addr_o),
        .wb_s_data_o   (wb_s_data_o)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic stop_sim();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s in test %s", what, test_name);
        stop_sim();
    endtask

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
            stop_sim();
        end
    endtask

    task automatic check_addr(input string what, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            stop_sim();
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
            stop_sim();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t r_type(input reg_addr_t rs, input reg_addr_t rt,
                                     input reg_addr_t rd, input logic [4:0] sa,
                                     input logic [5:0] fn);
        return {6'h00, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t i_type(input logic [5:0] opc, input reg_addr_t rs,
                                     input reg_addr_t rt, input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    // registers limited to r0..r7 so that dependencies show up often
    function automatic word_t random_inst();
        int          sel;
        logic [31:0] r;
        rng = xorshift32(rng);
        sel = int'(rng % 32'd17);
        rng = xorshift32(rng);
        r   = rng;
        if (sel < 11) begin
            return r_type({2'b00, r[2:0]}, {2'b00, r[5:3]}, {2'b00, r[8:6]}, r[13:9],
                          r_functs[sel]);
        end
        return i_type(i_opcodes[sel - 11], {2'b00, r[2:0]}, {2'b00, r[5:3]}, r[31:16]);
    endfunction

    // true when the instruction takes register r as a source operand
    function automatic bit reads_reg(input word_t inst, input reg_addr_t r);
        logic [5:0] opc;
        logic [5:0] fn;
        bit         use_rs;
        bit         use_rt;
        opc    = inst[31:26];
        fn     = inst[5:0];
        use_rs = 1'b0;
        use_rt = 1'b0;
        if (opc == opc_special) begin
            if (fn inside {fn_sll, fn_srl, fn_sra}) begin
                use_rt = 1'b1;
            end else if (fn inside {fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_nor,
                                    fn_slt, fn_sltu}) begin
                use_rs = 1'b1;
                use_rt = 1'b1;
            end
        end else if (opc inside {opc_addiu, opc_slti, opc_andi, opc_ori, opc_xori}) begin
            use_rs = 1'b1;
        end
        return (use_rs && (inst[25:21] == r)) || (use_rt && (inst[20:16] == r));
    endfunction

    // runs one instruction on model_regs and returns its write enable
    function automatic bit exec_inst(input word_t inst, output reg_addr_t waddr,
                                     output word_t result);
        logic [5:0]  opc;
        logic [5:0]  fn;
        logic [4:0]  sa;
        logic [15:0] imm;
        word_t       a;
        word_t       b;
        word_t       simm;
        bit          wen;
        opc    = inst[31:26];
        fn     = inst[5:0];
        sa     = inst[10:6];
        imm    = inst[15:0];
        a      = model_regs[inst[25:21]];
        b      = model_regs[inst[20:16]];
        simm   = {{16{imm[15]}}, imm};
        waddr  = inst[20:16];
        result = '0;
        wen    = 1'b1;
        if (opc == opc_special) begin
            waddr = inst[15:11];
            case (fn)
                fn_sll:  result = b << sa;
                fn_srl:  result = b >> sa;
                fn_sra:  result = $signed(b) >>> sa;
                fn_addu: result = a + b;
                fn_subu: result = a - b;
                fn_and:  result = a & b;
                fn_or:   result = a | b;
                fn_xor:  result = a ^ b;
                fn_nor:  result = ~(a | b);
                fn_slt:  result = {31'b0, $signed(a) < $signed(b)};
                fn_sltu: result = {31'b0, a < b};
                default: wen = 1'b0;
            endcase
        end else begin
            case (opc)
                opc_addiu: result = a + simm;
                opc_slti:  result = {31'b0, $signed(a) < $signed(simm)};
                opc_andi:  result = a & {16'b0, imm};
                opc_ori:   result = a | {16'b0, imm};
                opc_xori:  result = a ^ {16'b0, imm};
                opc_lui:   result = {imm, 16'b0};
                default:   wen = 1'b0;
            endcase
        end
        if (waddr == 5'd0) begin
            wen = 1'b0;
        end
        return wen;
    endfunction

    // each wb port must match the head of its queue or stay idle at every negedge
    always @(negedge clk) begin
        if (!reset_i) begin
            due_m = (exp_m.size() > 0) && (exp_m[0].at_edge == cycle);
            due_s = (exp_s.size() > 0) && (exp_s[0].at_edge == cycle);
            check_bit("wb_m_en_o", due_m, wb_m_en_o);
            check_bit("wb_s_en_o", due_s, wb_s_en_o);
            if (due_m) begin
                check_addr("wb_m_addr_o", exp_m[0].addr, wb_m_addr_o);
                check_word("wb_m_data_o", exp_m[0].data, wb_m_data_o);
                void'(exp_m.pop_front());
            end
            if (due_s) begin
                check_addr("wb_s_addr_o", exp_s[0].addr, wb_s_addr_o);
                check_word("wb_s_data_o", exp_s[0].data, wb_s_data_o);
                void'(exp_s.pop_front());
            end
        end
    end

    task automatic run_bundle(input string name, input word_t m_inst, input word_t s_inst);
        bit        m_wen;
        bit        s_wen;
        bit        split;
        reg_addr_t m_wa;
        reg_addr_t s_wa;
        word_t     m_res;
        word_t     s_res;
        wb_exp_t   e;
        int        k;
        int        ack_edge;
        int        fall_edge;
        int        waited;
        @(posedge clk);
        #1;
        test_name     = name;
        master_inst_i = m_inst;
        slave_inst_i  = s_inst;
        bundle_req_i  = 1'b1;
        k             = cycle + 1;
        m_wen = exec_inst(m_inst, m_wa, m_res);
        split = m_wen && reads_reg(s_inst, m_wa);
        if (m_wen) begin
            model_regs[m_wa] = m_res;
        end
        // slave runs after the master in program order
        s_wen = exec_inst(s_inst, s_wa, s_res);
        if (s_wen) begin
            model_regs[s_wa] = s_res;
        end
        ack_edge = split ? k + 2 : k + 1;
        if (m_wen) begin
            e.at_edge = k + 1;
            e.addr    = m_wa;
            e.data    = m_res;
            exp_m.push_back(e);
        end
        if (s_wen) begin
            e.at_edge = ack_edge;
            e.addr    = s_wa;
            e.data    = s_res;
            exp_s.push_back(e);
        end
        waited = 0;
        do begin
            @(negedge clk);
            check_bit("bundle_ack_o rise", cycle >= ack_edge, bundle_ack_o);
            waited++;
            if ((bundle_ack_o !== 1'b1) && (waited >= 10)) begin
                report_timeout("bundle_ack_o to rise");
            end
        end while (bundle_ack_o !== 1'b1);
        @(posedge clk);
        #1;
        bundle_req_i = 1'b0;
        fall_edge    = cycle + 1;
        waited       = 0;
        do begin
            @(negedge clk);
            check_bit("bundle_ack_o fall", cycle < fall_edge, bundle_ack_o);
            waited++;
            if ((bundle_ack_o !== 1'b0) && (waited >= 10)) begin
                report_timeout("bundle_ack_o to fall");
            end
        end while (bundle_ack_o !== 1'b0);
    endtask

    initial begin
        reset_i       = 1'b1;
        bundle_req_i  = 1'b0;
        master_inst_i = '0;
        slave_inst_i  = '0;
        for (int i = 0; i < num_regs; i++) begin
            model_regs[i] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        reset_i = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_bit("bundle_ack_o idle", 1'b0, bundle_ack_o);
        end

        run_bundle("independent", i_type(opc_ori, 5'd0, 5'd1, 16'h1234),
                   i_type(opc_lui, 5'd0, 5'd2, 16'habcd));
        run_bundle("dependent_rs", i_type(opc_addiu, 5'd1, 5'd3, 16'hfff0),
                   r_type(5'd3, 5'd2, 5'd4, 5'd0, fn_addu));
        run_bundle("dependent_rt", r_type(5'd1, 5'd2, 5'd5, 5'd0, fn_subu),
                   r_type(5'd0, 5'd5, 5'd6, 5'd4, fn_sra));

        for (int n = 0; n < 200; n++) begin
            run_bundle("random", random_inst(), random_inst());
        end

        run_bundle("r0_write", i_type(opc_ori, 5'd1, 5'd0, 16'h0055),
                   r_type(5'd1, 5'd0, 5'd0, 5'd0, fn_addu));
        run_bundle("r0_read", r_type(5'd0, 5'd0, 5'd7, 5'd0, fn_nor),
                   i_type(opc_addiu, 5'd0, 5'd1, 16'h0007));
        run_bundle("same_dest", i_type(opc_ori, 5'd0, 5'd6, 16'h0011),
                   i_type(opc_xori, 5'd0, 5'd6, 16'h0022));
        run_bundle("same_dest_read", r_type(5'd6, 5'd0, 5'd2, 5'd0, fn_or),
                   i_type(opc_lui, 5'd0, 5'd3, 16'h0000));

        // opcode 0x3f and funct 0x3f are outside the subset
        run_bundle("undef_master", 32'hfc42_1234, i_type(opc_ori, 5'd0, 5'd4, 16'h00aa));
        run_bundle("undef_slave", i_type(opc_ori, 5'd0, 5'd5, 16'h0005),
                   r_type(5'd5, 5'd5, 5'd6, 5'd0, 6'h3f));

        if ((exp_m.size() != 0) || (exp_s.size() != 0)) begin
            $display("expected writebacks never appeared on the wb ports");
            stop_sim();
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== dual_issue_core.f ====
core_pkg.sv
isa_pkg.sv
inst_decoder.sv
issue_ctrl.sv
lane_alu.sv
regfile.sv
dual_issue_core.sv
tb_dual_issue_core.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f dual_issue_core.f \
    --top-module tb_dual_issue_core \
    --Mdir obj_dir -o sim_dual_issue_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_dual_issue_core > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
exit 0
